//--- hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_and    = 4'd2;
    localparam logic [3:0] alu_or     = 4'd3;
    localparam logic [3:0] alu_xor    = 4'd4;
    localparam logic [3:0] alu_slt    = 4'd5;
    localparam logic [3:0] alu_pass_b = 4'd6;  // LUI, immediate straight through

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

endpackage

//--- hw/register_bank.sv
`timescale 1ns/1ps

module register_bank (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               enable,
    input  logic                               write_enable,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] write_address,
    input  logic [rv_pipe_pkg::xlen-1:0]       write_value,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] read_address1,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] read_address2,
    output logic [rv_pipe_pkg::xlen-1:0]       value1,
    output logic [rv_pipe_pkg::xlen-1:0]       value2
);
    logic [rv_pipe_pkg::xlen-1:0] regs [1:31];  // x0 has no storage
    logic                         writing;

    assign writing = enable & write_enable & (write_address != '0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writing) begin
            regs[write_address] <= write_value;
        end
    end

    // Same-cycle write shows up on the read ports
    always_comb begin
        if (read_address1 == '0)
            value1 = '0;
        else if (writing && read_address1 == write_address)
            value1 = write_value;
        else
            value1 = regs[read_address1];

        if (read_address2 == '0)
            value2 = '0;
        else if (writing && read_address2 == write_address)
            value2 = write_value;
        else
            value2 = regs[read_address2];
    end

endmodule

//--- hw/fetch.sv
`timescale 1ns/1ps

module fetch #(
    parameter int imem_words = 256
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic                          imem_write,     // Program load, reset only
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  logic [rv_pipe_pkg::xlen-1:0]  imem_data,
    input  logic                          branch_taken,
    input  logic [rv_pipe_pkg::xlen-1:0]  branch_target,
    output logic [rv_pipe_pkg::xlen-1:0]  pc,
    output logic [rv_pipe_pkg::xlen-1:0]  instr,
    output logic                          valid
);
    localparam int iaw = $clog2(imem_words);

    logic [rv_pipe_pkg::xlen-1:0] imem [imem_words];
    logic [rv_pipe_pkg::xlen-1:0] fetch_pc;

    always_ff @(posedge clock) begin
        if (imem_write)
            imem[imem_addr] <= imem_data;
    end

    // A redirect squashes the word being fetched this cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= '0;
            valid    <= 1'b0;
        end else if (enable) begin
            fetch_pc <= branch_taken ? branch_target : fetch_pc + 32'd4;
            valid    <= ~branch_taken;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            pc    <= fetch_pc;
            instr <= imem[fetch_pc[iaw+1:2]];  // Word index
        end
    end

endmodule

//--- hw/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               enable,
    input  logic                               flush,      // Taken branch in execute
    input  logic [rv_pipe_pkg::xlen-1:0]       instr_in,
    input  logic [rv_pipe_pkg::xlen-1:0]       pc_in,
    input  logic                               valid_in,
    input  logic [rv_pipe_pkg::xlen-1:0]       rs1_value,
    input  logic [rv_pipe_pkg::xlen-1:0]       rs2_value,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pipe_pkg::xlen-1:0]       pc,
    output logic [rv_pipe_pkg::xlen-1:0]       imm,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] rd,
    output logic [3:0]                         alu_op,
    output logic                               alu_src,
    output logic                               branch,
    output logic                               branch_ne,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic                               reg_write,
    output logic [rv_pipe_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pipe_pkg::xlen-1:0]       rs2_data,
    output logic                               valid
);
    rv_pipe_pkg::instr_u          word;
    logic [rv_pipe_pkg::xlen-1:0] imm_d;
    logic [3:0]                   alu_op_d;
    logic                         alu_src_d;
    logic                         branch_d;
    logic                         mem_read_d;
    logic                         mem_write_d;
    logic                         reg_write_d;
    logic                         supported;
    logic                         live;

    assign word = instr_in;
    assign rs1  = word.r.rs1;
    assign rs2  = word.r.rs2;
    assign live = valid_in & ~flush & supported;

    always_comb begin
        imm_d       = {{20{word.i.imm[11]}}, word.i.imm};
        alu_op_d    = rv_pipe_pkg::alu_add;
        alu_src_d   = 1'b0;
        branch_d    = 1'b0;
        mem_read_d  = 1'b0;
        mem_write_d = 1'b0;
        reg_write_d = 1'b0;
        supported   = 1'b1;
        case (word.r.opcode)
            rv_pipe_pkg::op_rtype: begin
                reg_write_d = 1'b1;
                case (word.r.funct3)
                    3'b000:  alu_op_d = word.r.funct7[5] ? rv_pipe_pkg::alu_sub
                                                         : rv_pipe_pkg::alu_add;
                    3'b111:  alu_op_d = rv_pipe_pkg::alu_and;
                    3'b110:  alu_op_d = rv_pipe_pkg::alu_or;
                    3'b100:  alu_op_d = rv_pipe_pkg::alu_xor;
                    3'b010:  alu_op_d = rv_pipe_pkg::alu_slt;
                    default: supported = 1'b0;
                endcase
            end
            rv_pipe_pkg::op_itype: begin  // ADDI only
                alu_src_d   = 1'b1;
                reg_write_d = 1'b1;
                supported   = (word.i.funct3 == 3'b000);
            end
            rv_pipe_pkg::op_lui: begin
                imm_d       = {word.i.imm, word.i.rs1, word.i.funct3, 12'b0};
                alu_op_d    = rv_pipe_pkg::alu_pass_b;
                alu_src_d   = 1'b1;
                reg_write_d = 1'b1;
            end
            rv_pipe_pkg::op_load: begin
                alu_src_d   = 1'b1;
                mem_read_d  = 1'b1;
                reg_write_d = 1'b1;
                supported   = (word.i.funct3 == 3'b010);
            end
            rv_pipe_pkg::op_store: begin
                imm_d       = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
                alu_src_d   = 1'b1;
                mem_write_d = 1'b1;
                supported   = (word.s.funct3 == 3'b010);
            end
            rv_pipe_pkg::op_branch: begin
                imm_d     = {{19{word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
                             word.b.imm_10_5, word.b.imm_4_1, 1'b0};
                branch_d  = 1'b1;
                supported = (word.b.funct3[2:1] == 2'b00);  // BEQ, BNE
            end
            default: supported = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            branch    <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
        end else if (enable) begin
            valid     <= valid_in & ~flush;
            branch    <= branch_d & live;     // Unsupported words become no-ops
            mem_read  <= mem_read_d & live;
            mem_write <= mem_write_d & live;
            reg_write <= reg_write_d & live;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            pc        <= pc_in;
            imm       <= imm_d;
            rd        <= word.r.rd;
            alu_op    <= alu_op_d;
            alu_src   <= alu_src_d;
            branch_ne <= word.b.funct3[0];
            rs1_data  <= rs1_value;
            rs2_data  <= rs2_value;
        end
    end

endmodule

//--- hw/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               enable,
    input  logic [rv_pipe_pkg::xlen-1:0]       pc,
    input  logic [rv_pipe_pkg::xlen-1:0]       imm,
    input  logic [rv_pipe_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pipe_pkg::xlen-1:0]       rs2_data,
    input  logic [3:0]                         alu_op,
    input  logic                               alu_src,
    input  logic                               branch,
    input  logic                               branch_ne,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] rd_in,
    input  logic                               mem_read_in,
    input  logic                               mem_write_in,
    input  logic                               reg_write_in,
    input  logic                               valid_in,
    output logic                               branch_taken,
    output logic [rv_pipe_pkg::xlen-1:0]       branch_target,
    output logic [rv_pipe_pkg::xlen-1:0]       result,
    output logic [rv_pipe_pkg::xlen-1:0]       store_data,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] rd,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic                               reg_write,
    output logic                               valid
);
    logic [rv_pipe_pkg::xlen-1:0] alu_b;
    logic [rv_pipe_pkg::xlen-1:0] alu_out;

    assign alu_b = alu_src ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            rv_pipe_pkg::alu_sub:    alu_out = rs1_data - alu_b;
            rv_pipe_pkg::alu_and:    alu_out = rs1_data & alu_b;
            rv_pipe_pkg::alu_or:     alu_out = rs1_data | alu_b;
            rv_pipe_pkg::alu_xor:    alu_out = rs1_data ^ alu_b;
            rv_pipe_pkg::alu_slt:    alu_out = {31'b0, $signed(rs1_data) < $signed(alu_b)};
            rv_pipe_pkg::alu_pass_b: alu_out = alu_b;
            default:                 alu_out = rs1_data + alu_b;  // Also address add
        endcase
    end

    // Branch is already cleared for squashed or invalid slots
    assign branch_taken  = branch & ((rs1_data == rs2_data) != branch_ne);
    assign branch_target = pc + imm;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
            valid     <= 1'b0;
        end else if (enable) begin
            mem_read  <= mem_read_in;
            mem_write <= mem_write_in;
            reg_write <= reg_write_in;
            valid     <= valid_in;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            result     <= alu_out;
            store_data <= rs2_data;
            rd         <= rd_in;
        end
    end

endmodule

//--- hw/memory.sv
`timescale 1ns/1ps

module memory #(
    parameter int dmem_words = 256
) (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               enable,
    input  logic [rv_pipe_pkg::xlen-1:0]       result,      // ALU value or address
    input  logic [rv_pipe_pkg::xlen-1:0]       store_data,
    input  logic [rv_pipe_pkg::reg_addr_w-1:0] rd,
    input  logic                               mem_read,
    input  logic                               mem_write,
    input  logic                               reg_write,
    input  logic                               valid,
    output logic                               wb_valid,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pipe_pkg::xlen-1:0]       wb_value
);
    localparam int daw = $clog2(dmem_words);

    logic [rv_pipe_pkg::xlen-1:0] ram [dmem_words];
    logic [daw-1:0]               word_addr;
    logic [rv_pipe_pkg::xlen-1:0] wb_next;
    logic                         retire;
    logic                         wb_valid_q;

    assign word_addr = result[daw+1:2];
    assign wb_next   = mem_read ? ram[word_addr] : result;  // Combinational load
    assign retire    = valid & reg_write & (rd != '0);

    always_ff @(posedge clock) begin
        if (enable && valid && mem_write)
            ram[word_addr] <= store_data;
    end

    // wb_value keeps the last value written, which drives led
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
            wb_rd      <= '0;
            wb_value   <= '0;
        end else if (enable) begin
            wb_valid_q <= retire;
            if (retire) begin
                wb_rd    <= rd;
                wb_value <= wb_next;
            end
        end
    end

    // A held write-back only counts once the pipe moves again
    assign wb_valid = wb_valid_q & enable;

endmodule

//--- hw/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               enable,       // Stalls every stage when low
    input  logic                               imem_write,
    input  logic [$clog2(imem_words)-1:0]      imem_addr,
    input  logic [rv_pipe_pkg::xlen-1:0]       imem_data,
    output logic                               wb_valid,
    output logic [rv_pipe_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pipe_pkg::xlen-1:0]       wb_value,
    output logic [5:0]                         led
);
    // Fetch to decode
    logic [rv_pipe_pkg::xlen-1:0]       if_de_pc;
    logic [rv_pipe_pkg::xlen-1:0]       if_de_instr;
    logic                               if_de_valid;

    // Decode and register bank
    logic [rv_pipe_pkg::reg_addr_w-1:0] rb_read_address1;
    logic [rv_pipe_pkg::reg_addr_w-1:0] rb_read_address2;
    logic [rv_pipe_pkg::xlen-1:0]       rb_value1;
    logic [rv_pipe_pkg::xlen-1:0]       rb_value2;

    // Decode to execute
    logic [rv_pipe_pkg::xlen-1:0]       de_ex_pc;
    logic [rv_pipe_pkg::xlen-1:0]       de_ex_imm;
    logic [rv_pipe_pkg::reg_addr_w-1:0] de_ex_rd;
    logic [3:0]                         de_ex_alu_op;
    logic                               de_ex_alu_src;
    logic                               de_ex_branch;
    logic                               de_ex_branch_ne;
    logic                               de_ex_mem_read;
    logic                               de_ex_mem_write;
    logic                               de_ex_reg_write;
    logic [rv_pipe_pkg::xlen-1:0]       de_ex_rs1_data;
    logic [rv_pipe_pkg::xlen-1:0]       de_ex_rs2_data;
    logic                               de_ex_valid;

    // Execute back to fetch and decode
    logic                               branch_taken;
    logic [rv_pipe_pkg::xlen-1:0]       branch_target;

    // Execute to memory
    logic [rv_pipe_pkg::xlen-1:0]       ex_mem_result;
    logic [rv_pipe_pkg::xlen-1:0]       ex_mem_store_data;
    logic [rv_pipe_pkg::reg_addr_w-1:0] ex_mem_rd;
    logic                               ex_mem_mem_read;
    logic                               ex_mem_mem_write;
    logic                               ex_mem_reg_write;
    logic                               ex_mem_valid;

    assign led = wb_value[5:0];

    fetch #(.imem_words(imem_words)) fetch0 (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .imem_write(imem_write), .imem_addr(imem_addr), .imem_data(imem_data),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .pc(if_de_pc), .instr(if_de_instr), .valid(if_de_valid)
    );

    decode decode0 (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .flush(branch_taken),  // Squash the younger slot
        .instr_in(if_de_instr), .pc_in(if_de_pc), .valid_in(if_de_valid),
        .rs1_value(rb_value1), .rs2_value(rb_value2),
        .rs1(rb_read_address1), .rs2(rb_read_address2),
        .pc(de_ex_pc), .imm(de_ex_imm), .rd(de_ex_rd),
        .alu_op(de_ex_alu_op), .alu_src(de_ex_alu_src),
        .branch(de_ex_branch), .branch_ne(de_ex_branch_ne),
        .mem_read(de_ex_mem_read), .mem_write(de_ex_mem_write),
        .reg_write(de_ex_reg_write),
        .rs1_data(de_ex_rs1_data), .rs2_data(de_ex_rs2_data), .valid(de_ex_valid)
    );

    execute execute0 (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .pc(de_ex_pc), .imm(de_ex_imm),
        .rs1_data(de_ex_rs1_data), .rs2_data(de_ex_rs2_data),
        .alu_op(de_ex_alu_op), .alu_src(de_ex_alu_src),
        .branch(de_ex_branch), .branch_ne(de_ex_branch_ne),
        .rd_in(de_ex_rd), .mem_read_in(de_ex_mem_read), .mem_write_in(de_ex_mem_write),
        .reg_write_in(de_ex_reg_write), .valid_in(de_ex_valid),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .result(ex_mem_result), .store_data(ex_mem_store_data), .rd(ex_mem_rd),
        .mem_read(ex_mem_mem_read), .mem_write(ex_mem_mem_write),
        .reg_write(ex_mem_reg_write), .valid(ex_mem_valid)
    );

    memory #(.dmem_words(dmem_words)) memory0 (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .result(ex_mem_result), .store_data(ex_mem_store_data), .rd(ex_mem_rd),
        .mem_read(ex_mem_mem_read), .mem_write(ex_mem_mem_write),
        .reg_write(ex_mem_reg_write), .valid(ex_mem_valid),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_value(wb_value)
    );

    // Write-back comes straight from the memory stage register
    register_bank register_bank0 (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .write_enable(wb_valid), .write_address(wb_rd), .write_value(wb_value),
        .read_address1(rb_read_address1), .read_address2(rb_read_address2),
        .value1(rb_value1), .value2(rb_value2)
    );

endmodule

//--- tests/cpu_assert.sv
`timescale 1ns/1ps

module cpu_assert (
    input logic                               clock,
    input logic                               rst_n,
    input logic                               enable,
    input logic                               wb_valid,
    input logic [rv_pipe_pkg::reg_addr_w-1:0] wb_rd,
    input logic [rv_pipe_pkg::xlen-1:0]       wb_value
);

    assert property (@(posedge clock) disable iff (!rst_n) wb_valid |-> !$isunknown(wb_value))
        else $error("wb_value has unknown bits during a write-back");

    // Writes to x0 never leave the memory stage
    assert property (@(posedge clock) disable iff (!rst_n) wb_valid |-> wb_rd != '0)
        else $error("write-back pulse with destination x0");

    // The write-back register holds through a stalled cycle
    assert property (@(posedge clock) disable iff (!rst_n)
                     !enable |=> $stable(wb_rd) && $stable(wb_value))
        else $error("write-back register changed while the pipeline was stalled");

endmodule

bind cpu cpu_assert assert0 (
    .clock(clock), .rst_n(rst_n), .enable(enable),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_value(wb_value)
);

//--- tests/cpu_programs.svh
// Each row is one test that runs after its own reset
localparam int n_tests    = 6;
localparam int n_programs = 4;
localparam int prog_words = 24;

// Programs padded with the canonical nop 32'h00000013
localparam logic [31:0] programs [n_programs][prog_words] = '{
    '{32'h01900093, 32'hff900113, 32'h123451b7, 32'h00000013, 32'h00000013, 32'h00208233,
      32'h402082b3, 32'h0020f333, 32'h0020e3b3, 32'h0020c433, 32'h001124b3, 32'h00118533,
      32'h7ff18593, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
    '{32'h04000093, 32'habcde137, 32'hed400193, 32'h00000013, 32'h00000013, 32'h0020a023,
      32'h0030a423, 32'hfe10ae23, 32'h0000a203, 32'h0080a283, 32'hffc0a303, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
    '{32'h00500093, 32'h00500113, 32'h00900193, 32'h00000013, 32'h00000013, 32'h00208863,
      32'h00100213, 32'h00200293, 32'h00300313, 32'h00309663, 32'h00400393, 32'h00500413,
      32'h00308463, 32'h00600493, 32'h00209463, 32'h00700513, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
    '{32'h04d00013, 32'h00300093, 32'h55555037, 32'h00000013, 32'h00000013, 32'h00100133,
      32'h000061b3, 32'hfff00213, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013}
};

string test_names [n_tests] = '{"alu", "alu_random", "store_load", "branch", "x0", "enable_hold"};

localparam int prog_sel [n_tests] = '{0, 0, 1, 2, 3, 1};
localparam int budgets  [n_tests] = '{40, 40, 40, 40, 40, 56};  // Cycles to the last write
localparam int hold_at  [n_tests] = '{0, 0, 0, 0, 0, 4};
localparam int hold_len [n_tests] = '{0, 0, 0, 0, 0, 9};        // Enable low this long
localparam int rand_ops [n_tests] = '{0, 1, 0, 0, 0, 0};

//--- tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    localparam int reset_cycles = 10;
    localparam int drain_cycles = 4;  // Idle cycles that must stay free of writes

    logic        clock;
    logic        rst_n;
    logic        enable;
    logic        imem_write;
    logic [7:0]  imem_addr;
    logic [31:0] imem_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_value;
    logic [5:0]  led;

    `include "cpu_programs.svh"

    logic [31:0] prog [prog_words];  // Program of the current row
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    logic [31:0] lcg_state = 32'hcc4d;

    cpu #(.imem_words(256), .dmem_words(256)) dut0 (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .imem_write(imem_write), .imem_addr(imem_addr), .imem_data(imem_data),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_value(wb_value), .led(led)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Copy a row's program, random rows get fresh LUI and ADDI operands
    task automatic load_row(input int t);
        rv_pipe_pkg::instr_u w;
        logic [31:0]         r;
        for (int k = 0; k < prog_words; k++) begin
            prog[k] = programs[prog_sel[t]][k];
            w = prog[k];
            if (rand_ops[t] != 0) begin
                r = next_rand();
                if (w.r.opcode == rv_pipe_pkg::op_lui) begin
                    prog[k][31:12] = r[31:12];
                end else if (w.r.opcode == rv_pipe_pkg::op_itype && w.i.rd != 5'd0) begin
                    w.i.imm = r[27:16];
                    prog[k] = w;
                end
            end
        end
    endtask

    // ISA model, in program order, with no notion of the pipeline
    task automatic build_expected();
        logic [31:0]         regs [32];
        logic [31:0]         dmem [256];
        rv_pipe_pkg::instr_u w;
        logic [31:0]         word;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         imm;
        logic [31:0]         addr;
        logic [31:0]         res;
        logic                wr;
        logic [31:0]         pc;
        logic [31:0]         next_pc;
        int                  steps;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        exp_rd.delete();
        exp_val.delete();
        pc = '0;
        steps = 0;
        while (pc < 4 * prog_words && steps < 64) begin
            word = prog[pc[6:2]];
            w = word;
            a = regs[w.r.rs1];
            b = regs[w.r.rs2];
            imm = {{20{w.i.imm[11]}}, w.i.imm};
            res = '0;
            wr = 1'b0;
            next_pc = pc + 32'd4;
            case (w.r.opcode)
                rv_pipe_pkg::op_rtype: begin
                    wr = 1'b1;
                    case (w.r.funct3)
                        3'b000:  res = w.r.funct7[5] ? a - b : a + b;
                        3'b111:  res = a & b;
                        3'b110:  res = a | b;
                        3'b100:  res = a ^ b;
                        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                rv_pipe_pkg::op_itype: begin
                    res = a + imm;
                    wr = 1'b1;
                end
                rv_pipe_pkg::op_lui: begin
                    res = {word[31:12], 12'b0};
                    wr = 1'b1;
                end
                rv_pipe_pkg::op_load: begin
                    addr = a + imm;
                    res = dmem[addr[9:2]];
                    wr = 1'b1;
                end
                rv_pipe_pkg::op_store: begin
                    addr = a + {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
                    dmem[addr[9:2]] = b;
                end
                rv_pipe_pkg::op_branch: begin
                    if ((a == b) != w.b.funct3[0])
                        next_pc = pc + {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
                                        w.b.imm_10_5, w.b.imm_4_1, 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && w.r.rd != 5'd0) begin
                regs[w.r.rd] = res;
                exp_rd.push_back(w.r.rd);
                exp_val.push_back(res);
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic reset_and_load();
        @(negedge clock);
        rst_n = 1'b0;
        enable = 1'b0;
        for (int k = 0; k < prog_words; k++) begin
            @(negedge clock);
            imem_write = 1'b1;
            imem_addr = 8'(k);
            imem_data = prog[k];
        end
        @(negedge clock);
        imem_write = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        rst_n = 1'b1;
        enable = 1'b1;
    endtask

    // Drive on the falling edge, sample 1 ns later
    task automatic step_cycle(input int t, input int c, inout int got, inout int test_errors);
        @(negedge clock);
        enable = (c >= hold_at[t] && c < hold_at[t] + hold_len[t]) ? 1'b0 : 1'b1;
        #1;
        if (wb_valid) begin
            if (!enable) begin
                $display("test %s: write-back seen while enable was low", test_names[t]);
                test_errors++;
            end
            if (got >= exp_rd.size()) begin
                $display("test %s: unexpected extra write x%0d = %h at %0t",
                         test_names[t], wb_rd, wb_value, $time);
                test_errors++;
            end else if (wb_rd !== exp_rd[got] || wb_value !== exp_val[got]) begin
                $display("error at %0t: %s write %0d gave x%0d = %h, expected x%0d = %h",
                         $time, test_names[t], got, wb_rd, wb_value, exp_rd[got], exp_val[got]);
                test_errors++;
            end
            got++;
        end
    endtask

    task automatic run_test(input int t, output int test_errors);
        int c;
        int got;
        test_errors = 0;
        got = 0;
        c = 0;
        while (got < exp_rd.size() && c < budgets[t]) begin
            step_cycle(t, c, got, test_errors);
            c++;
        end
        if (got < exp_rd.size()) begin
            $display("test %s: only %0d of %0d writes arrived within %0d cycles",
                     test_names[t], got, exp_rd.size(), budgets[t]);
            test_errors++;
        end
        repeat (drain_cycles) begin
            step_cycle(t, c, got, test_errors);
            c++;
        end
    endtask

    initial begin
        int          test_errors;
        int          errors;
        int          passed;
        int          failed;
        logic [31:0] last;
        rst_n = 1'b0;
        enable = 1'b0;
        imem_write = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        errors = 0;
        passed = 0;
        failed = 0;
        for (int t = 0; t < n_tests; t++) begin
            load_row(t);
            build_expected();
            reset_and_load();
            run_test(t, test_errors);
            last = (exp_val.size() > 0) ? exp_val[$] : 32'd0;
            if (led !== last[5:0]) begin
                $display("error at %0t: %s led = %h, expected %h",
                         $time, test_names[t], led, last[5:0]);
                test_errors++;
            end
            if (test_errors == 0) begin
                passed++;
                $display("test %s: pass, %0d writes", test_names[t], exp_rd.size());
            end else begin
                failed++;
                $display("test %s: FAIL, %0d errors", test_names[t], test_errors);
            end
            errors += test_errors;
        end
        $display("%0d tests: %0d passed, %0d failed, %0d errors", n_tests, passed, failed, errors);
        if (failed == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Upper bound on the whole run, from the table
    initial begin
        int limit;
        limit = 1;
        for (int t = 0; t < n_tests; t++) begin
            limit += prog_words + reset_cycles + 3 + budgets[t] + drain_cycles;
        end
        repeat (limit) @(posedge clock);
        $display("timeout: the run went past %0d cycles", limit);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- rv_pipe.f
+incdir+tests
hw/rv_pipe_pkg.sv
hw/register_bank.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/cpu.sv
tests/cpu_assert.sv
tests/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
LOG       ?= sim.log
FILELIST  ?= rv_pipe.f
OBJ_DIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tests/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
